//--- Makefile
SIM      := verilator
TOP      := lsq_tb
FILELIST := lsq.f
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP)
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))
LOG      := sim.log
PASS     := Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- load_arbiter.sv
/*
 * fixed-priority cache port for the load slots, lowest slot first.
 * one load outstanding; the reply is steered back to its owner.
 */
module load_arbiter import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   squash,
    input  logic [num_ls-1:0]      req,
    input  word_t [num_ls-1:0]     req_addr,
    input  mem_size_t [num_ls-1:0] req_size,
    input  logic                   load_resp_valid,
    input  word_t                  load_resp_value,
    output mem_req_t               mem_req,
    output logic [num_ls-1:0]      grant_resp,
    output word_t                  resp_value
);

    logic      busy;
    ls_idx_t   owner;
    ls_idx_t   pick;
    logic      any_req;
    word_t     out_addr;
    mem_size_t out_size;

    // priority encoder, the last hit of the downward loop wins
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = num_ls - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick    = ls_idx_t'(i);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            busy  <= 1'b0;
            owner <= '0;
        end else if (!busy && any_req) begin
            busy  <= 1'b1;
            owner <= pick;
        end else if (busy && load_resp_valid) begin
            busy  <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!busy && any_req) begin
            out_addr <= req_addr[pick];
            out_size <= req_size[pick];
        end
    end

    always_comb begin
        grant_resp = '0;
        if (busy && load_resp_valid) begin
            grant_resp[owner] = 1'b1;
        end
    end

    assign mem_req.valid = busy;
    assign mem_req.addr  = out_addr;
    assign mem_req.size  = out_size;
    assign resp_value    = load_resp_value;

endmodule

//--- load_slot.sv
/*
 * one load entry. records its older stores at dispatch, then forwards from
 * the youngest matching one or asks the cache through the arbiter.
 */
module load_slot import lsq_pkg::*; (
    input  logic         clock,
    input  logic         rst,
    input  logic         squash,
    input  logic         alloc,
    input  exec_t        fill,
    input  sq_view_t     view,
    input  sq_mask_t     freed,
    input  logic         grant_resp,
    input  word_t        resp_value,
    output logic         req,
    output word_t        req_addr,
    output mem_size_t    req_size,
    output load_result_t result
);

    slot_state_t state;
    sq_mask_t    older;       // stores ahead of this load in program order
    sq_mask_t    live;
    sq_idx_t     cap_tail;
    word_t       ld_addr;
    mem_size_t   ld_size;
    word_t       ld_value;
    logic        addr_in;
    logic        stall;
    logic        hit;
    word_t       fwd_value;

    assign addr_in = fill.valid && fill.is_load;

    always_comb begin
        for (int i = 0; i < sq_size; i++) begin
            live[i] = view.entries[i].valid;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // backward scan from the captured tail
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        sq_idx_t pos;
        logic    stop;
        stall     = 1'b0;
        hit       = 1'b0;
        fwd_value = '0;
        stop      = 1'b0;
        pos       = cap_tail;
        for (int k = 0; k < sq_size; k++) begin
            pos = pos - 1'b1;
            if (!stop && older[pos]) begin
                if (!view.entries[pos].filled) begin
                    // address unknown yet, cannot look past it
                    stall = 1'b1;
                    stop  = 1'b1;
                end else if (view.entries[pos].addr == ld_addr &&
                             view.entries[pos].size == ld_size) begin
                    hit       = 1'b1;
                    fwd_value = view.entries[pos].value;
                    stop      = 1'b1;
                end
            end
        end
    end

    // slot FSM
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            state <= idle;
            older <= '0;
        end else if (alloc) begin
            state <= wait_addr;
            older <= live & ~freed;
        end else begin
            older <= older & ~freed;
            case (state)
                wait_addr: if (addr_in) state <= search;
                search: begin
                    if (hit) begin
                        state <= done;
                    end else if (!stall) begin
                        state <= wait_mem;
                    end
                end
                wait_mem:  if (grant_resp) state <= done;
                done:      state <= idle;
                default:   state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            cap_tail <= view.tail;
        end
        if (state == wait_addr && addr_in) begin
            ld_addr <= fill.addr;
            ld_size <= fill.size;
        end
        if (state == search && hit) begin
            ld_value <= fwd_value;
        end else if (state == wait_mem && grant_resp) begin
            ld_value <= resp_value;
        end
    end

    assign req          = (state == wait_mem);
    assign req_addr     = ld_addr;
    assign req_size     = ld_size;
    assign result.done  = (state == done);
    assign result.value = ld_value;

endmodule

//--- lsq.f
lsq_pkg.sv
store_queue.sv
load_slot.sv
load_arbiter.sv
lsq_top.sv
lsq_checker.sv
lsq_tb.sv

//--- lsq_checker.sv
/*
 * watches the lsq outputs and compares load results, cache reads and stores
 * and status levels with the values that the testbench queues up.
 */
module lsq_checker import lsq_pkg::*; (
    input logic                      clock,
    input logic                      rst,
    input sq_idx_t                   sq_tail,
    input logic                      sq_full,
    input mem_store_t                mem_store,
    input mem_req_t                  mem_req,
    input load_result_t [num_ls-1:0] results
);
    timeunit 1ns;
    timeprecision 1ps;

    int         load_errors  = 0;
    int         store_errors = 0;
    int         other_errors = 0;
    word_t      exp_load [num_ls][$];   // oldest first within each slot
    word_t      exp_addr [num_ls];      // address of the load each slot holds
    mem_size_t  exp_size [num_ls];
    mem_store_t exp_store [$];          // cache commit order
    logic       store_seen = 1'b0;
    logic       req_seen   = 1'b0;

    task automatic compare(input string name, input word_t got, input word_t exp,
                           input int kind);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            case (kind)
                0:       load_errors++;
                1:       store_errors++;
                default: other_errors++;
            endcase
        end
    endtask

    task automatic note_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        other_errors++;
    endtask

    task automatic expect_load(input int slot, input word_t addr, input word_t size,
                               input word_t value);
        exp_addr[slot] = addr;
        exp_size[slot] = mem_size_t'(size);
        exp_load[slot].push_back(value);
    endtask

    task automatic expect_store(input word_t addr, input word_t size, input word_t value);
        mem_store_t e;
        e.valid = 1'b1;
        e.addr  = addr;
        e.size  = mem_size_t'(size);
        e.value = value;
        exp_store.push_back(e);
    endtask

    function automatic int loads_pending();
        int total;
        total = 0;
        for (int i = 0; i < num_ls; i++) begin
            total += exp_load[i].size();
        end
        return total;
    endfunction

    function automatic int stores_pending();
        return exp_store.size();
    endfunction

    // a cache read belongs to some load that is still waiting
    function automatic logic read_matches_load();
        logic found;
        found = 1'b0;
        for (int i = 0; i < num_ls; i++) begin
            if (exp_load[i].size() != 0 && mem_req.addr == exp_addr[i] &&
                mem_req.size == exp_size[i]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_tail(input sq_idx_t tail);
        compare("sq_tail", word_t'(sq_tail), word_t'(tail), 2);
    endtask

    // quiet state with nothing in flight towards the cache and no done
    task automatic check_idle(input logic full, input sq_idx_t tail);
        compare("sq_full", word_t'(sq_full), word_t'(full), 2);
        compare("sq_tail", word_t'(sq_tail), word_t'(tail), 2);
        compare("mem_req.valid", word_t'(mem_req.valid), '0, 2);
        compare("mem_store.valid", word_t'(mem_store.valid), '0, 2);
        for (int i = 0; i < num_ls; i++) begin
            compare($sformatf("results[%0d].done", i), word_t'(results[i].done), '0, 2);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // load results and cache stores
    //////////////////////////////////////////////////////////////////////
    always @(posedge clock) begin
        mem_store_t want;
        if (!rst) begin
            for (int i = 0; i < num_ls; i++) begin
                if (results[i].done && exp_load[i].size() == 0) begin
                    note_failure($sformatf("slot %0d returned a load that was not expected", i));
                end else if (results[i].done) begin
                    compare($sformatf("results[%0d].value", i), results[i].value,
                            exp_load[i].pop_front(), 0);
                end
            end
            // new read on the cache port
            if (mem_req.valid && !req_seen && !read_matches_load()) begin
                note_failure($sformatf("cache read of %h size %0d matches no waiting load",
                                       mem_req.addr, mem_req.size));
            end
            req_seen = mem_req.valid;
            // new store on the cache port
            if (mem_store.valid && !store_seen) begin
                if (exp_store.size() == 0) begin
                    note_failure("a store reached the cache that was not expected");
                end else begin
                    want = exp_store.pop_front();
                    compare("mem_store.addr", mem_store.addr, want.addr, 1);
                    compare("mem_store.size", word_t'(mem_store.size), word_t'(want.size), 1);
                    compare("mem_store.value", mem_store.value, want.value, 1);
                end
            end
            store_seen = mem_store.valid;
        end
    end

endmodule

//--- lsq_pkg.sv
/*
 * shared sizes, vector types and packed structs of the load/store queue.
 * every lsq module pulls these in with a wildcard import.
 */
package lsq_pkg;

    localparam int xlen     = 32;
    localparam int sq_size  = 8;
    localparam int num_ls   = 4;
    localparam int sq_idx_w = $clog2(sq_size);
    localparam int ls_idx_w = $clog2(num_ls);

    typedef logic [sq_idx_w-1:0] sq_idx_t;
    typedef logic [sq_idx_w:0]   sq_cnt_t;   // 0 .. sq_size stores
    typedef logic [sq_size-1:0]  sq_mask_t;
    typedef logic [ls_idx_w-1:0] ls_idx_t;
    typedef logic [xlen-1:0]     word_t;
    typedef logic [1:0]          mem_size_t; // byte, half, word

    typedef struct packed {
        logic    valid;
        logic    is_store;
        logic    is_load;
        ls_idx_t slot;
    } dispatch_t;

    // one execute lane; lane i carries the load of slot i
    typedef struct packed {
        logic      valid;
        logic      is_store;
        logic      is_load;
        ls_idx_t   slot;
        sq_idx_t   sq_pos;
        word_t     addr;
        mem_size_t size;
        word_t     value;
    } exec_t;

    typedef struct packed {
        logic      valid;
        logic      filled;
        word_t     addr;
        mem_size_t size;
        word_t     value;
    } sq_entry_t;

    typedef struct packed {
        sq_entry_t [sq_size-1:0] entries;
        sq_idx_t                 head;
        sq_idx_t                 tail;
    } sq_view_t;

    typedef struct packed {
        logic      valid;
        word_t     addr;
        mem_size_t size;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        word_t     addr;
        mem_size_t size;
        word_t     value;
    } mem_store_t;

    typedef struct packed {
        logic  done;
        word_t value;
    } load_result_t;

    typedef enum logic [2:0] {
        idle,
        wait_addr,
        search,
        wait_mem,
        done
    } slot_state_t;

endpackage

//--- lsq_tb.sv
/*
 * testbench for lsq_top. replays the operations of lsq_tests.txt on the
 * falling clock edge and stands in for the data cache.
 */
module lsq_tb import lsq_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 200;

    logic                      clock = 1'b0;
    logic                      rst;
    logic                      squash;
    dispatch_t                 dispatch;
    exec_t [num_ls-1:0]        exec;
    logic                      rob_retire;
    logic                      store_done;
    logic                      load_resp_valid;
    word_t                     load_resp_value;
    sq_idx_t                   sq_tail;
    logic                      sq_full;
    mem_store_t                mem_store;
    mem_req_t                  mem_req;
    load_result_t [num_ls-1:0] results;

    logic [31:0] lfsr;
    word_t       mem [word_t];   // words written by committed stores
    logic        load_busy;
    logic        store_busy;
    int          load_wait;
    int          store_wait;
    logic        aborted;

    lsq_top uut (.*);

    lsq_checker chk (.*);

    initial begin
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // reply delay of 1 to 4 cycles from two lfsr bits
    task automatic draw_delay(output int cycles);
        logic [1:0] r;
        lfsr = lfsr_next(lfsr);
        r[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        r[1] = lfsr[0];
        cycles = 1 + int'(r);
    endtask

    // untouched words hold address xor 5a5a5a5a
    function automatic word_t mem_read(input word_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'h5a5a5a5a;
    endfunction

    task automatic tick();
        @(negedge clock);
    endtask

    //////////////////////////////////////////////////////////////////////
    // data cache model
    //////////////////////////////////////////////////////////////////////
    initial begin
        load_resp_valid = 1'b0;
        load_resp_value = '0;
        store_done      = 1'b0;
        load_busy       = 1'b0;
        store_busy      = 1'b0;
        load_wait       = 0;
        store_wait      = 0;
        lfsr            = 32'hdde7c943;
        forever begin
            @(negedge clock);
            load_resp_valid = 1'b0;
            store_done      = 1'b0;
            if (load_busy) begin
                load_wait--;
                if (load_wait == 0) begin
                    load_resp_valid = 1'b1;
                    load_resp_value = mem_read(mem_req.addr);
                    load_busy       = 1'b0;
                end
            end else if (mem_req.valid) begin
                draw_delay(load_wait);
                load_busy = 1'b1;
            end
            if (store_busy) begin
                store_wait--;
                if (store_wait == 0) begin
                    mem[mem_store.addr] = mem_store.value;
                    store_done          = 1'b1;
                    store_busy          = 1'b0;
                end
            end else if (mem_store.valid) begin
                draw_delay(store_wait);
                store_busy = 1'b1;
            end
        end
    end

    task automatic wait_loads();
        int cycles;
        cycles = 0;
        while (chk.loads_pending() != 0 && cycles < wait_limit) begin
            tick();
            cycles++;
        end
        if (chk.loads_pending() != 0) begin
            chk.note_failure("timed out waiting for load results");
            aborted = 1'b1;
        end
    endtask

    // until every expected store is seen and the last one is acknowledged
    task automatic wait_stores();
        int cycles;
        cycles = 0;
        while ((chk.stores_pending() != 0 || mem_store.valid) && cycles < wait_limit) begin
            tick();
            cycles++;
        end
        if (chk.stores_pending() != 0 || mem_store.valid) begin
            chk.note_failure("timed out waiting for stores to reach the cache");
            aborted = 1'b1;
        end
    endtask

    task automatic run_op(input logic [15:0] op, input word_t a, input word_t b,
                          input word_t c, input word_t d);
        exec_t lane;
        lane = '0;
        case (op)
            "ds": begin
                for (int k = 0; k < int'(b); k++) begin
                    chk.check_tail(sq_idx_t'(a + word_t'(k)));
                    dispatch.valid    = 1'b1;
                    dispatch.is_store = 1'b1;
                    tick();
                    dispatch = '0;
                end
            end
            "dl": begin
                dispatch.valid   = 1'b1;
                dispatch.is_load = 1'b1;
                dispatch.slot    = ls_idx_t'(a);
                tick();
                dispatch = '0;
            end
            "es": begin
                lane.valid    = 1'b1;
                lane.is_store = 1'b1;
                lane.sq_pos   = sq_idx_t'(a);
                lane.addr     = b;
                lane.size     = mem_size_t'(c);
                lane.value    = d;
                exec[0]       = lane;
                tick();
                exec = '0;
            end
            "el": begin
                chk.expect_load(int'(a), b, c, d);
                lane.valid           = 1'b1;
                lane.is_load         = 1'b1;
                lane.slot            = ls_idx_t'(a);
                lane.addr            = b;
                lane.size            = mem_size_t'(c);
                exec[ls_idx_t'(a)]   = lane;
                tick();
                exec = '0;
            end
            "ec": chk.expect_store(a, b, c);
            "rt": begin
                for (int k = 0; k < int'(a); k++) begin
                    rob_retire = 1'b1;
                    tick();
                    rob_retire = 1'b0;
                end
            end
            "wl": wait_loads();
            "wc": wait_stores();
            "wn": begin
                for (int k = 0; k < int'(a); k++) begin
                    tick();
                end
            end
            "sq": begin
                squash = 1'b1;
                tick();
                squash = 1'b0;
            end
            "st": chk.check_idle(a[0], sq_idx_t'(b));
            default: begin
                chk.note_failure($sformatf("unknown operation %s in the test file", op));
                aborted = 1'b1;
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        string       line;
        logic [15:0] op;
        word_t       a;
        word_t       b;
        word_t       c;
        word_t       d;
        rst        = 1'b1;
        squash     = 1'b0;
        dispatch   = '0;
        exec       = '0;
        rob_retire = 1'b0;
        aborted    = 1'b0;
        op         = '0;
        a          = '0;
        b          = '0;
        c          = '0;
        d          = '0;
        repeat (3) tick();
        rst = 1'b0;
        fd = $fopen("lsq_tests.txt", "r");
        if (fd == 0) begin
            chk.note_failure("cannot open lsq_tests.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) != 0) begin
            // skip blank and comment lines
            if (line.len() > 1 && line[0] != "#") begin
                void'($sscanf(line, "%s %h %h %h %h", op, a, b, c, d));
                run_op(op, a, b, c, d);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        tick();
        $display("errors: load %0d, store %0d, other %0d",
                 chk.load_errors, chk.store_errors, chk.other_errors);
        if (chk.load_errors + chk.store_errors + chk.other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- lsq_tests.txt
# op a b c d, hex: ds pos count | dl slot | es pos addr size value | el slot addr size expect
# ec addr size value | rt count | wl, wc | wn cycles | sq | st full tail
dl 0
el 0 100 2 5a5a5b5a
wl
ds 0 1
es 0 200 2 11111111
dl 1
el 1 200 2 11111111
wl
ds 1 2
es 1 200 2 22222222
es 2 200 0 33333333
dl 2
el 2 200 2 22222222
wl
ds 3 1
dl 3
el 3 300 2 44444444
wn 6
es 3 300 2 44444444
wl
ec 200 2 11111111
ec 200 2 22222222
ec 200 0 33333333
ec 300 2 44444444
rt 4
wc
dl 0
dl 1
dl 2
el 0 300 2 44444444
el 1 104 2 5a5a5b5e
el 2 108 2 5a5a5b52
wl
st 0 4
ds 4 8
st 1 4
es 4 400 2 55555555
ec 400 2 55555555
rt 1
wc
st 0 4
sq
st 0 0

//--- lsq_top.sv
/*
 * load/store queue top: store queue, the generated load slots and the
 * load arbiter in front of the data cache.
 */
module lsq_top import lsq_pkg::*; (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      squash,
    input  dispatch_t                 dispatch,
    input  exec_t [num_ls-1:0]        exec,
    input  logic                      rob_retire,
    input  logic                      store_done,
    input  logic                      load_resp_valid,
    input  word_t                     load_resp_value,
    output sq_idx_t                   sq_tail,
    output logic                      sq_full,
    output mem_store_t                mem_store,
    output mem_req_t                  mem_req,
    output load_result_t [num_ls-1:0] results
);

    sq_view_t               view;
    sq_mask_t               freed;
    logic [num_ls-1:0]      req;
    word_t [num_ls-1:0]     req_addr;
    mem_size_t [num_ls-1:0] req_size;
    logic [num_ls-1:0]      grant_resp;
    word_t                  resp_value;

    store_queue u_sq (
        .clock      (clock),
        .rst        (rst),
        .squash     (squash),
        .dispatch   (dispatch),
        .exec       (exec),
        .rob_retire (rob_retire),
        .store_done (store_done),
        .view       (view),
        .sq_tail    (sq_tail),
        .sq_full    (sq_full),
        .mem_store  (mem_store),
        .freed      (freed)
    );

    for (genvar i = 0; i < num_ls; i++) begin : g_slot
        load_slot u_slot (
            .clock      (clock),
            .rst        (rst),
            .squash     (squash),
            .alloc      (dispatch.valid && dispatch.is_load && dispatch.slot == ls_idx_t'(i)),
            .fill       (exec[i]),
            .view       (view),
            .freed      (freed),
            .grant_resp (grant_resp[i]),
            .resp_value (resp_value),
            .req        (req[i]),
            .req_addr   (req_addr[i]),
            .req_size   (req_size[i]),
            .result     (results[i])
        );
    end

    load_arbiter u_arb (
        .clock           (clock),
        .rst             (rst),
        .squash          (squash),
        .req             (req),
        .req_addr        (req_addr),
        .req_size        (req_size),
        .load_resp_valid (load_resp_valid),
        .load_resp_value (load_resp_value),
        .mem_req         (mem_req),
        .grant_resp      (grant_resp),
        .resp_value      (resp_value)
    );

endmodule

//--- store_queue.sv
/*
 * circular store buffer. stores are reserved at dispatch, filled by the execute
 * lanes, written to the cache in program order and exposed for forwarding.
 */
module store_queue import lsq_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               squash,
    input  dispatch_t          dispatch,
    input  exec_t [num_ls-1:0] exec,
    input  logic               rob_retire,
    input  logic               store_done,
    output sq_view_t           view,
    output sq_idx_t            sq_tail,
    output logic               sq_full,
    output mem_store_t         mem_store,
    output sq_mask_t           freed
);

    sq_idx_t   head;
    sq_idx_t   tail;
    sq_cnt_t   count;
    sq_cnt_t   pend;          // retired stores not yet sent to the cache
    sq_mask_t  valid_q;
    sq_mask_t  filled_q;
    word_t     addr_q  [sq_size];
    mem_size_t size_q  [sq_size];
    word_t     value_q [sq_size];
    logic      store_busy;
    word_t     commit_addr;
    mem_size_t commit_size;
    word_t     commit_value;
    logic      alloc;
    logic      commit;
    logic      release_head;

    assign alloc        = dispatch.valid && dispatch.is_store;
    assign release_head = store_done && store_busy;
    // head goes out once retired, only one store in flight
    assign commit       = (rob_retire || pend != '0) && !store_busy && filled_q[head];

    ////////////////////////////////////////////////////////////////////
    // pointers and entry status
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            pend       <= '0;
            valid_q    <= '0;
            filled_q   <= '0;
            store_busy <= 1'b0;
        end else begin
            if (alloc) begin
                valid_q[tail]  <= 1'b1;
                filled_q[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            for (int i = 0; i < num_ls; i++) begin
                if (exec[i].valid && exec[i].is_store) begin
                    filled_q[exec[i].sq_pos] <= 1'b1;
                end
            end
            if (release_head) begin
                valid_q[head]  <= 1'b0;
                filled_q[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            count <= count + sq_cnt_t'(alloc) - sq_cnt_t'(release_head);
            pend  <= pend + sq_cnt_t'(rob_retire) - sq_cnt_t'(commit);
            if (commit) begin
                store_busy <= 1'b1;
            end else if (release_head) begin
                store_busy <= 1'b0;
            end
        end
    end

    // entry payload and the outgoing store
    always_ff @(posedge clock) begin
        for (int i = 0; i < num_ls; i++) begin
            if (exec[i].valid && exec[i].is_store) begin
                addr_q[exec[i].sq_pos]  <= exec[i].addr;
                size_q[exec[i].sq_pos]  <= exec[i].size;
                value_q[exec[i].sq_pos] <= exec[i].value;
            end
        end
        if (commit) begin
            commit_addr  <= addr_q[head];
            commit_size  <= size_q[head];
            commit_value <= value_q[head];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < sq_size; i++) begin
            view.entries[i].valid  = valid_q[i];
            view.entries[i].filled = filled_q[i];
            view.entries[i].addr   = addr_q[i];
            view.entries[i].size   = size_q[i];
            view.entries[i].value  = value_q[i];
        end
        view.head = head;
        view.tail = tail;
    end

    // one-hot of the entry leaving this cycle
    always_comb begin
        freed = '0;
        if (release_head) begin
            freed[head] = 1'b1;
        end
    end

    assign mem_store.valid = store_busy;
    assign mem_store.addr  = commit_addr;
    assign mem_store.size  = commit_size;
    assign mem_store.value = commit_value;

    assign sq_tail = tail;
    assign sq_full = (count == sq_cnt_t'(sq_size));

endmodule
